// File: verilog/mem_if_bus_pkg.sv
package mem_if_bus_pkg;

  // **************************************************
  // memory port
  // **************************************************
  typedef logic [15:0] mem_addr_t;  // word address
  typedef logic [63:0] mem_word_t;

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    mem_addr_t adr;
    mem_word_t dat;
  } mem_req_t;

  typedef struct packed {
    logic      ack;
    mem_word_t dat;
  } mem_rsp_t;

  // **************************************************
  // host register port
  // **************************************************
  typedef logic [31:0] reg_data_t;
  typedef logic [2:0]  reg_addr_t;  // register index

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat;
  } host_req_t;

  typedef struct packed {
    logic      ack;
    reg_data_t dat;
  } host_rsp_t;

endpackage

// File: verilog/mem_if_cfg_pkg.sv
package mem_if_cfg_pkg;

  localparam int LANES = 4;      // lanes per memory word

  typedef logic [15:0] lane_t;   // one PE element
  typedef logic [1:0]  shift_t;  // lane rotation
  typedef logic [15:0] word_count_t;

  // register map
  localparam logic [2:0] REG_CTRL    = 3'd0;
  localparam logic [2:0] REG_RD_ADDR = 3'd1;
  localparam logic [2:0] REG_COUNT   = 3'd2;
  localparam logic [2:0] REG_WR_ADDR = 3'd3;
  localparam logic [2:0] REG_SHIFT   = 3'd4;
  localparam logic [2:0] REG_STATUS  = 3'd5;  // read only

  typedef struct packed {
    word_count_t stored;  // words written back
    logic [13:0] rsvd;
    logic        done;
    logic        busy;
  } status_t;

endpackage

// File: verilog/cfg_regs.sv
`timescale 1ns/10ps

module cfg_regs
  import mem_if_bus_pkg::*, mem_if_cfg_pkg::*;
(
  input  logic        ACLK,
  input  logic        ARESETN,
  input  host_req_t   host_req,
  output host_rsp_t   host_rsp,
  input  word_count_t words_stored,
  input  logic        last_store,
  output mem_addr_t   rd_base,
  output mem_addr_t   wr_base,
  output word_count_t job_len,
  output shift_t      shift,
  output logic        start,
  output logic        busy
);

  reg_data_t ctrl_q;
  reg_data_t rd_addr_q;
  reg_data_t count_q;
  reg_data_t wr_addr_q;
  reg_data_t shift_q;
  reg_data_t rdata_q;
  logic      ack_q;
  logic      ctrl_d;    // bit 0, one cycle late
  logic      toggle_q;  // bit 0 changed
  logic      busy_q;
  logic      done_q;
  logic      access;
  status_t   status;

  // new strobe, not yet answered
  assign access = host_req.cyc && host_req.stb && !ack_q;

  assign status = '{stored: words_stored, rsvd: '0, done: done_q, busy: busy_q};

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      ack_q     <= 1'b0;
      ctrl_q    <= '0;
      rd_addr_q <= '0;
      count_q   <= '0;
      wr_addr_q <= '0;
      shift_q   <= '0;
      ctrl_d    <= 1'b0;
      toggle_q  <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && host_req.we) begin
        case (host_req.adr)
          REG_CTRL:    ctrl_q    <= host_req.dat;
          REG_RD_ADDR: rd_addr_q <= host_req.dat;
          REG_COUNT:   count_q   <= host_req.dat;
          REG_WR_ADDR: wr_addr_q <= host_req.dat;
          REG_SHIFT:   shift_q   <= host_req.dat;
          default:     ;  // status and holes
        endcase
      end
      ctrl_d   <= ctrl_q[0];
      toggle_q <= ctrl_q[0] ^ ctrl_d;  // lands one cycle after ack
      if (start) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (last_store) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // read data follows the held address, valid in the ack cycle
  always_ff @(posedge ACLK) begin
    case (host_req.adr)
      REG_CTRL:    rdata_q <= ctrl_q;
      REG_RD_ADDR: rdata_q <= rd_addr_q;
      REG_COUNT:   rdata_q <= count_q;
      REG_WR_ADDR: rdata_q <= wr_addr_q;
      REG_SHIFT:   rdata_q <= shift_q;
      REG_STATUS:  rdata_q <= status;
      default:     rdata_q <= '0;
    endcase
  end

  assign host_rsp = '{ack: ack_q, dat: rdata_q};
  assign rd_base  = mem_addr_t'(rd_addr_q);
  assign wr_base  = mem_addr_t'(wr_addr_q);
  assign job_len  = word_count_t'(count_q);
  assign shift    = shift_t'(shift_q);
  assign start    = toggle_q && !busy_q;  // no restart mid job
  assign busy     = busy_q;

  // every ack answers a strobe seen one cycle earlier
  a_ack_after_stb: assert property (@(posedge ACLK) disable iff (!ARESETN)
    host_rsp.ack |-> $past(host_req.cyc && host_req.stb));

endmodule

// File: verilog/word_fifo.sv
`timescale 1ns/10ps

module word_fifo
  import mem_if_bus_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 3
) (
  input  logic      ACLK,
  input  logic      ARESETN,
  input  logic      push,
  input  mem_word_t push_data,
  input  logic      pop,
  output mem_word_t front,
  output logic      empty,
  output logic      full
);

  localparam int DEPTH = 1 << BUF_DEPTH_LOG2;

  mem_word_t                 mem [DEPTH];
  logic [BUF_DEPTH_LOG2-1:0] wr_ptr;
  logic [BUF_DEPTH_LOG2-1:0] rd_ptr;
  logic [BUF_DEPTH_LOG2:0]   count;  // occupancy, 0 to DEPTH

  always_ff @(posedge ACLK) begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // pointers wrap
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign front = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = count[BUF_DEPTH_LOG2];  // msb only set at DEPTH

  a_no_push_full: assert property (@(posedge ACLK) disable iff (!ARESETN)
    push |-> !full);
  a_no_pop_empty: assert property (@(posedge ACLK) disable iff (!ARESETN)
    pop |-> !empty);

endmodule

// File: verilog/fetch_engine.sv
`timescale 1ns/10ps

module fetch_engine
  import mem_if_bus_pkg::*, mem_if_cfg_pkg::*;
(
  input  logic        ACLK,
  input  logic        ARESETN,
  input  logic        start,
  input  mem_addr_t   rd_base,
  input  word_count_t job_len,
  output mem_req_t    bus_req,
  input  mem_rsp_t    bus_rsp,
  input  logic        buf_full,
  output logic        buf_push,
  output mem_word_t   buf_data
);

  typedef enum logic [1:0] {idle, request, wait_ack} fetch_state_t;

  fetch_state_t state;
  mem_addr_t    addr_q;
  word_count_t  remain_q;  // words still to read
  logic         in_cycle;

  assign in_cycle = (state == wait_ack);

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      state    <= idle;
      addr_q   <= '0;
      remain_q <= '0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            addr_q   <= rd_base;
            remain_q <= job_len;
            state    <= request;
          end
        end
        request: begin
          if (remain_q == '0)
            state <= idle;
          else if (!buf_full)  // room is kept, only this side pushes
            state <= wait_ack;
        end
        wait_ack: begin
          if (bus_rsp.ack) begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            state    <= request;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign bus_req  = '{cyc: in_cycle, stb: in_cycle, we: 1'b0, adr: addr_q, dat: '0};
  assign buf_push = in_cycle && bus_rsp.ack;
  assign buf_data = bus_rsp.dat;

  // the read stays on the bus until the arbiter routes its ack back
  a_stb_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
    bus_req.stb && !bus_rsp.ack |=> bus_req.stb);

endmodule

// File: verilog/lane_shifter.sv
`timescale 1ns/10ps

module lane_shifter
  import mem_if_bus_pkg::*, mem_if_cfg_pkg::*;
(
  input  logic      ACLK,
  input  logic      ARESETN,
  input  shift_t    shift,
  input  logic      buf_empty,
  output logic      buf_pop,
  input  mem_word_t buf_front,
  output mem_word_t pe_data,
  output logic      pe_valid,
  input  logic      pe_ready
);

  localparam int LANE_W = $bits(lane_t);

  // out lane i takes in lane (i + s) mod LANES, lane 0 at the bottom
  function automatic mem_word_t rotate(mem_word_t w, shift_t s);
    mem_word_t r;
    lane_t     l;
    r = '0;
    for (int i = 0; i < LANES; i++) begin
      l = w[((i + s) % LANES) * LANE_W +: LANE_W];
      r[i * LANE_W +: LANE_W] = l;
    end
    return r;
  endfunction

  // refill when empty or drained this cycle
  assign buf_pop = !buf_empty && (!pe_valid || pe_ready);

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN)
      pe_valid <= 1'b0;
    else if (buf_pop)
      pe_valid <= 1'b1;
    else if (pe_ready)
      pe_valid <= 1'b0;
  end

  always_ff @(posedge ACLK) begin
    if (buf_pop)
      pe_data <= rotate(buf_front, shift);  // holds while stalled
  end

endmodule

// File: verilog/store_engine.sv
`timescale 1ns/10ps

module store_engine
  import mem_if_bus_pkg::*, mem_if_cfg_pkg::*;
(
  input  logic        ACLK,
  input  logic        ARESETN,
  input  logic        start,
  input  mem_addr_t   wr_base,
  input  word_count_t job_len,
  input  logic        buf_empty,
  output logic        buf_pop,
  input  mem_word_t   buf_front,
  output mem_req_t    bus_req,
  input  mem_rsp_t    bus_rsp,
  output word_count_t words_stored,
  output logic        last_store
);

  typedef enum logic [1:0] {idle, request, wait_ack} store_state_t;

  store_state_t state;
  mem_addr_t    base_q;
  word_count_t  len_q;
  word_count_t  count_q;  // words acked so far
  mem_addr_t    wr_adr;
  logic         in_cycle;
  logic         acked;

  assign in_cycle = (state == wait_ack);
  assign acked    = in_cycle && bus_rsp.ack;
  assign wr_adr   = base_q + count_q;

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      state   <= idle;
      base_q  <= '0;
      len_q   <= '0;
      count_q <= '0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            base_q  <= wr_base;
            len_q   <= job_len;
            count_q <= '0;
            state   <= request;
          end
        end
        request: begin
          if (count_q == len_q)
            state <= idle;
          else if (!buf_empty)
            state <= wait_ack;
        end
        wait_ack: begin
          if (bus_rsp.ack) begin
            count_q <= count_q + 1'b1;
            state   <= request;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // front word stays put until the write is acked
  assign bus_req = '{cyc: in_cycle, stb: in_cycle, we: in_cycle, adr: wr_adr,
                     dat: buf_front};

  assign buf_pop      = acked;
  assign words_stored = count_q;
  assign last_store   = acked && (count_q + 1'b1 == len_q);

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
  import mem_if_bus_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESETN,
  input  mem_req_t fetch_req,
  output mem_rsp_t fetch_rsp,
  input  mem_req_t store_req,
  output mem_rsp_t store_rsp,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  logic held_q;     // bus had a cycle last clock
  logic owner_q;    // 1 = store, current or last owner
  logic owner_cyc;
  logic grant;

  assign owner_cyc = owner_q ? store_req.cyc : fetch_req.cyc;

  always_comb begin
    if (held_q && owner_cyc)
      grant = owner_q;  // keep until cyc drops
    else if (fetch_req.cyc && store_req.cyc)
      grant = !owner_q;  // both waiting, take turns
    else
      grant = store_req.cyc;
  end

  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      held_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      held_q <= mem_req.cyc;
      if (mem_req.cyc)
        owner_q <= grant;
    end
  end

  assign mem_req   = grant ? store_req : fetch_req;
  assign fetch_rsp = '{ack: mem_rsp.ack && !grant, dat: mem_rsp.dat};
  assign store_rsp = '{ack: mem_rsp.ack && grant, dat: mem_rsp.dat};

  a_ack_needs_cyc: assert property (@(posedge ACLK) disable iff (!ARESETN)
    mem_rsp.ack |-> mem_req.cyc);

endmodule

// File: verilog/mem_interface.sv
`timescale 1ns/10ps

module mem_interface
  import mem_if_bus_pkg::*, mem_if_cfg_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 3
) (
  input  logic      ACLK,
  input  logic      ARESETN,
  input  host_req_t host_req,
  output host_rsp_t host_rsp,
  output mem_req_t  mem_req,
  input  mem_rsp_t  mem_rsp,
  output mem_word_t pe_data,
  output logic      pe_valid,
  input  logic      pe_ready,
  input  mem_word_t res_data,
  input  logic      res_valid,
  output logic      res_ready
);

  mem_addr_t   rd_base;
  mem_addr_t   wr_base;
  word_count_t job_len;
  shift_t      shift;
  logic        start;
  word_count_t words_stored;
  logic        last_store;
  mem_req_t    fetch_req;
  mem_rsp_t    fetch_rsp;
  mem_req_t    store_req;
  mem_rsp_t    store_rsp;
  logic        rd_push;
  mem_word_t   rd_data;
  logic        rd_pop;
  mem_word_t   rd_front;
  logic        rd_empty;
  logic        rd_full;
  logic        wr_push;
  logic        wr_pop;
  mem_word_t   wr_front;
  logic        wr_empty;
  logic        wr_full;

  assign wr_push   = res_valid && res_ready;
  assign res_ready = !wr_full;

  // **************************************************
  // host registers
  // **************************************************
  cfg_regs u_cfg_regs (
    .ACLK         (ACLK),
    .ARESETN      (ARESETN),
    .host_req     (host_req),
    .host_rsp     (host_rsp),
    .words_stored (words_stored),
    .last_store   (last_store),
    .rd_base      (rd_base),
    .wr_base      (wr_base),
    .job_len      (job_len),
    .shift        (shift),
    .start        (start),
    .busy         ()           // seen through status
  );

  // **************************************************
  // read path, memory to PE array
  // **************************************************
  fetch_engine u_fetch (
    .ACLK     (ACLK),
    .ARESETN  (ARESETN),
    .start    (start),
    .rd_base  (rd_base),
    .job_len  (job_len),
    .bus_req  (fetch_req),
    .bus_rsp  (fetch_rsp),
    .buf_full (rd_full),
    .buf_push (rd_push),
    .buf_data (rd_data)
  );

  word_fifo #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) u_rd_buf (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .push      (rd_push),
    .push_data (rd_data),
    .pop       (rd_pop),
    .front     (rd_front),
    .empty     (rd_empty),
    .full      (rd_full)
  );

  lane_shifter u_shifter (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .shift     (shift),
    .buf_empty (rd_empty),
    .buf_pop   (rd_pop),
    .buf_front (rd_front),
    .pe_data   (pe_data),
    .pe_valid  (pe_valid),
    .pe_ready  (pe_ready)
  );

  // **************************************************
  // write path, results back to memory
  // **************************************************
  word_fifo #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) u_wr_buf (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .push      (wr_push),
    .push_data (res_data),
    .pop       (wr_pop),
    .front     (wr_front),
    .empty     (wr_empty),
    .full      (wr_full)
  );

  store_engine u_store (
    .ACLK         (ACLK),
    .ARESETN      (ARESETN),
    .start        (start),
    .wr_base      (wr_base),
    .job_len      (job_len),
    .buf_empty    (wr_empty),
    .buf_pop      (wr_pop),
    .buf_front    (wr_front),
    .bus_req      (store_req),
    .bus_rsp      (store_rsp),
    .words_stored (words_stored),
    .last_store   (last_store)
  );

  mem_arbiter u_arbiter (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .store_req (store_req),
    .store_rsp (store_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic ACLK
);

  localparam time HALF_PERIOD = 20ns;  // 40 ns clock

  initial ACLK = 1'b0;

  always #(HALF_PERIOD) ACLK = ~ACLK;

endmodule

// File: tests/tb_mem_interface.sv
`timescale 1ns/10ps

module tb_mem_interface
  import mem_if_bus_pkg::*, mem_if_cfg_pkg::*;
();

  localparam int SEED        = 89415;
  localparam int ACK_TIMEOUT = 8;    // cycles per host access
  localparam int DONE_POLLS  = 300;  // status reads per job
  localparam int IDLE_CYCLES = 20;

  logic      ACLK;
  logic      ARESETN;
  host_req_t host_req;
  host_rsp_t host_rsp;
  mem_req_t  mem_req;
  mem_rsp_t  mem_rsp = '0;
  mem_word_t pe_data;
  logic      pe_valid;
  logic      pe_ready = 1'b0;
  mem_word_t res_data = '0;
  logic      res_valid = 1'b0;
  logic      res_ready;

  mem_word_t   mem_model [mem_addr_t];  // what the DUT sees
  mem_word_t   file_mem [mem_addr_t];   // preload as read from the file
  mem_addr_t   job_rd [$];
  word_count_t job_cnt [$];
  mem_addr_t   job_wr [$];
  shift_t      job_sh [$];
  mem_word_t   exp_pe [$];
  mem_word_t   loop_q [$];              // words held by the PE loopback
  reg_data_t   ctrl_val = '0;
  int          value_errs = 0;
  int          other_errs = 0;
  logic        aborted = 1'b0;
  logic        pending = 1'b0;
  int          delay = 0;

  tb_clock u_clock (.ACLK(ACLK));

  mem_interface #(.BUF_DEPTH_LOG2(3)) uut (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .pe_data   (pe_data),
    .pe_valid  (pe_valid),
    .pe_ready  (pe_ready),
    .res_data  (res_data),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  // unwritten locations read back a pattern built from the address
  function automatic mem_word_t mem_fill(mem_addr_t a);
    return {a, ~a, a ^ 16'h5a5a, a + 16'h1234};
  endfunction

  function automatic mem_word_t mem_peek(mem_addr_t a);
    return mem_model.exists(a) ? mem_model[a] : mem_fill(a);
  endfunction

  function automatic mem_word_t file_word(mem_addr_t a);
    return file_mem.exists(a) ? file_mem[a] : mem_fill(a);
  endfunction

  // lane s lands in lane 0 by a right rotate of s lanes
  function automatic mem_word_t rotated(mem_word_t w, shift_t s);
    int nbits;
    nbits = $bits(lane_t) * int'(s);
    return (w >> nbits) | (w << ($bits(mem_word_t) - nbits));
  endfunction

  task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  // **************************************************
  // memory model and PE loopback
  // **************************************************
  always @(posedge ACLK) begin
    if (!ARESETN) begin
      mem_rsp <= '0;
      pending = 1'b0;
    end else if (mem_rsp.ack) begin
      mem_rsp <= '0;  // one cycle of ack
    end else if (mem_req.cyc && mem_req.stb) begin
      if (!pending) begin
        pending = 1'b1;
        delay = $urandom_range(3, 0);
      end
      if (delay == 0) begin
        pending = 1'b0;
        if (mem_req.we) begin
          mem_model[mem_req.adr] = mem_req.dat;
          mem_rsp <= '{ack: 1'b1, dat: '0};
        end else begin
          mem_rsp <= '{ack: 1'b1, dat: mem_peek(mem_req.adr)};
        end
      end else begin
        delay--;
      end
    end
  end

  always @(posedge ACLK) begin
    if (ARESETN) begin
      if (pe_valid && pe_ready) begin
        if (exp_pe.size() == 0) begin
          $display("ERROR: a pe_data word arrived at %0d ns with no job running", $time);
          other_errs++;
        end else begin
          check_word("pe_data", pe_data, exp_pe.pop_front());
        end
        loop_q.push_back(pe_data);
      end
      if (!(res_valid && !res_ready)) begin  // hold while stalled
        if (loop_q.size() > 0 && $urandom_range(2, 0) != 0) begin
          res_valid <= 1'b1;
          res_data  <= loop_q.pop_front();
        end else begin
          res_valid <= 1'b0;
        end
      end
      pe_ready <= ($urandom_range(1, 0) == 1);
    end
  end

  // **************************************************
  // host driver
  // **************************************************
  task automatic host_access(input logic we, input reg_addr_t adr, input reg_data_t wdat,
                             output reg_data_t rdat);
    int waited;
    rdat = '0;
    waited = 0;
    if (aborted)
      return;
    @(posedge ACLK);
    host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(posedge ACLK);
      waited++;
    end while (!host_rsp.ack && waited < ACK_TIMEOUT);
    if (!host_rsp.ack) begin
      $display("ERROR: register %0d gave no ack within %0d cycles", adr, ACK_TIMEOUT);
      other_errs++;
      aborted = 1'b1;
    end
    rdat = host_rsp.dat;
    host_req <= '0;
  endtask

  task automatic wait_done(output reg_data_t st);
    int polls;
    polls = 0;
    do begin
      host_access(1'b0, REG_STATUS, '0, st);
      polls++;
    end while (!aborted && !st[1] && polls < DONE_POLLS);
    if (!aborted && !st[1]) begin
      $display("ERROR: job not done after %0d status reads", DONE_POLLS);
      other_errs++;
      aborted = 1'b1;
    end
  endtask

  task automatic watch_bus_idle();
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(posedge ACLK);
      if (mem_req.cyc || pe_valid) begin
        $display("ERROR: a job started at %0d ns without a change of bit 0", $time);
        other_errs++;
        break;
      end
    end
  endtask

  task automatic load_vectors();
    int             fd;
    int             n;
    logic [7:0]     tag;
    logic [8*120:1] rest;
    mem_addr_t      a;
    mem_word_t      d;
    mem_addr_t      rd;
    word_count_t    cnt;
    mem_addr_t      wr;
    shift_t         sh;
    fd = $fopen("tests/mem_if_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open tests/mem_if_vectors.txt");
      other_errs++;
      aborted = 1'b1;
      return;
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "m") begin
        n = $fscanf(fd, "%h %h", a, d);
        if (n != 2) begin
          $display("ERROR: a memory line in the vector file is incomplete");
          other_errs++;
        end
        file_mem[a]  = d;
        mem_model[a] = d;
      end else if (tag == "j") begin
        n = $fscanf(fd, "%h %h %h %h", rd, cnt, wr, sh);
        if (n != 4) begin
          $display("ERROR: a job line in the vector file is incomplete");
          other_errs++;
        end
        job_rd.push_back(rd);
        job_cnt.push_back(cnt);
        job_wr.push_back(wr);
        job_sh.push_back(sh);
      end else begin
        n = $fgets(rest, fd);  // comment line
      end
    end
    $fclose(fd);
  endtask

  task automatic check_registers();
    reg_data_t rd;
    for (int r = 1; r <= 4; r++)
      host_access(1'b1, reg_addr_t'(r), 32'h5a00_0000 + r * 32'h0011_0101, rd);
    for (int r = 1; r <= 4; r++) begin
      host_access(1'b0, reg_addr_t'(r), '0, rd);
      check_reg($sformatf("reg[%0d]", r), rd, 32'h5a00_0000 + r * 32'h0011_0101);
    end
    host_access(1'b1, 3'd6, 32'hdead_beef, rd);
    host_access(1'b0, 3'd6, '0, rd);
    check_reg("reg[6]", rd, '0);
    host_access(1'b1, REG_STATUS, 32'hffff_ffff, rd);
    host_access(1'b0, REG_STATUS, '0, rd);  // busy and done low too
    check_reg("status", rd, '0);
  endtask

  task automatic run_job(input int j);
    mem_addr_t   rd;
    mem_addr_t   wr;
    word_count_t cnt;
    shift_t      sh;
    reg_data_t   st_before;
    reg_data_t   st;
    mem_word_t   area [$];
    mem_addr_t   a;
    rd  = job_rd[j];
    wr  = job_wr[j];
    cnt = job_cnt[j];
    sh  = job_sh[j];
    host_access(1'b1, REG_RD_ADDR, reg_data_t'(rd), st);
    host_access(1'b1, REG_COUNT, reg_data_t'(cnt), st);
    host_access(1'b1, REG_WR_ADDR, reg_data_t'(wr), st);
    host_access(1'b1, REG_SHIFT, reg_data_t'(sh), st);
    host_access(1'b0, REG_STATUS, '0, st_before);
    for (int i = 0; i < int'(cnt); i++)
      area.push_back(mem_peek(mem_addr_t'(wr + i)));
    // other bits move while bit 0 stays
    ctrl_val = ctrl_val ^ 32'h0000_0100;
    host_access(1'b1, REG_CTRL, ctrl_val, st);
    watch_bus_idle();
    host_access(1'b0, REG_STATUS, '0, st);
    if (aborted)
      return;
    check_reg("status", st, st_before);
    for (int i = 0; i < int'(cnt); i++) begin
      a = mem_addr_t'(wr + i);
      check_word($sformatf("mem[%h]", a), mem_peek(a), area[i]);
    end
    for (int i = 0; i < int'(cnt); i++)
      exp_pe.push_back(rotated(file_word(mem_addr_t'(rd + i)), sh));
    ctrl_val = ctrl_val ^ 32'h0000_0001;  // the real start
    host_access(1'b1, REG_CTRL, ctrl_val, st);
    wait_done(st);
    if (aborted)
      return;
    check_reg("status", st, {cnt, 14'b0, 1'b1, 1'b0});
    if (exp_pe.size() != 0) begin
      $display("ERROR: job %0d ended with %0d pe_data words missing", j, exp_pe.size());
      other_errs++;
      exp_pe.delete();
    end
    for (int i = 0; i < int'(cnt); i++) begin
      a = mem_addr_t'(wr + i);
      check_word($sformatf("mem[%h]", a), mem_peek(a),
                 rotated(file_word(mem_addr_t'(rd + i)), sh));
    end
  endtask

  // **************************************************
  // main sequence
  // **************************************************
  initial begin
    void'($urandom(SEED));
    ARESETN  = 1'b0;
    host_req = '0;
    load_vectors();
    repeat (5) @(posedge ACLK);
    ARESETN <= 1'b1;
    @(posedge ACLK);
    check_reg("host_rsp.ack", reg_data_t'(host_rsp.ack), '0);
    check_reg("mem_req.cyc", reg_data_t'(mem_req.cyc), '0);
    check_reg("mem_req.stb", reg_data_t'(mem_req.stb), '0);
    check_reg("pe_valid", reg_data_t'(pe_valid), '0);
    check_reg("res_ready", reg_data_t'(res_ready), 32'd1);
    check_registers();
    for (int j = 0; j < job_rd.size() && !aborted; j++)
      run_job(j);
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: tests/mem_if_vectors.txt
# m <addr> <data>                        memory preload, hex
# j <rd_addr> <count> <wr_addr> <shift>  job, hex
m 0100 1a031a021a011a00
m 0101 2b132b122b112b10
m 0102 3c233c223c213c20
m 0103 4d334d324d314d30
m 0104 5e435e425e415e40
m 0105 6f536f526f516f50
m 0106 7063706270617060
m 0107 8173817281718170
m 0108 9283928292819280
m 0109 a393a392a391a390
m 010a b4a3b4a2b4a1b4a0
m 010b c5b3c5b2c5b1c5b0
j 0100 4 0200 1
j 0104 6 0300 3
j 0100 c 0400 0
j 0106 5 0500 2

// File: filelist.f
verilog/mem_if_bus_pkg.sv
verilog/mem_if_cfg_pkg.sv
verilog/cfg_regs.sv
verilog/word_fifo.sv
verilog/fetch_engine.sv
verilog/lane_shifter.sv
verilog/store_engine.sv
verilog/mem_arbiter.sv
verilog/mem_interface.sv
tests/tb_clock.sv
tests/tb_mem_interface.sv

// File: Makefile
TOP = tb_mem_interface

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -sv --assert --timing -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir
